// ==== dv/dct_2d_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module dct_2d_checker (
    input  logic                clk,
    input  logic                arst_n,
    input  dct_pkg::sample_t    di [8],
    input  logic                di_valid,
    input  logic                di_hold,
    input  dct_pkg::coef2_t     q [2],
    input  logic                q_valid,
    input  logic                q_hold,
    input  scan_pkg::pair_cnt_t q_cnt,
    input  int                  test_id,    // Tag driven with each row
    output int                  err_cnt,
    output int                  blk_in,     // Blocks captured at di
    output int                  blk_out     // Blocks fully checked at q
);

    localparam int n_pairs = 32;

    int   cmat [64];        // Scaled cosines, k*8 + n
    int   zz [64];          // Zigzag position -> natural index
    int   x_blk [64];       // Block being captured
    int   exp_q [$];        // Expected coefficients, scan order
    int   tid_q [$];        // Test tag per expected pair
    int   in_row;
    int   blk_tid;
    int   beat_idx;
    logic rst_seen;         // Reset was active on the last edge

    function automatic int round_real(real v);
        if (v >= 0.0) begin
            return $rtoi(v + 0.5);
        end
        return -$rtoi(0.5 - v);
    endfunction

    // Two's complement wrap to w bits
    function automatic int wrap(int v, int w);
        int t;
        t = v & ((1 << w) - 1);
        if (t >= (1 << (w - 1))) begin
            t = t - (1 << w);
        end
        return t;
    endfunction

    function automatic string test_name(int id);
        case (id)
            0:       return "const";
            1:       return "full_rate";
            2:       return "backpressure";
            3:       return "impulse";
            4:       return "extreme";
            default: return "unknown";
        endcase
    endfunction

    // --------------------------------------------------
    // Reference tables, built from the transform rules
    // --------------------------------------------------
    initial begin : build_tables
        real pi;
        real ck;
        int  p;
        int  r;
        int  c;
        pi = 3.14159265358979;
        for (int k = 0; k < 8; k++) begin
            ck = (k == 0) ? $sqrt(0.125) : 0.5;
            for (int n = 0; n < 8; n++) begin
                cmat[k*8+n] = round_real(64.0 * ck * $cos((2 * n + 1) * k * pi / 16.0));
            end
        end
        p = 0;
        for (int s = 0; s < 15; s++) begin     // Anti-diagonals, direction alternates
            for (int i = 0; i < 8; i++) begin
                r = (s % 2 == 1) ? i : 7 - i;  // Odd goes down, even goes up
                c = s - r;
                if (c >= 0 && c < 8) begin
                    zz[p] = r * 8 + c;
                    p = p + 1;
                end
            end
        end
        err_cnt  = 0;
        blk_in   = 0;
        blk_out  = 0;
        in_row   = 0;
        beat_idx = 0;
        rst_seen = 1'b0;
    end

    // Row pass, column pass, scan reorder
    task automatic push_block();
        int y [64];
        int z [64];
        int s;
        for (int r = 0; r < 8; r++) begin
            for (int k = 0; k < 8; k++) begin
                s = 0;
                for (int n = 0; n < 8; n++) begin
                    s = s + x_blk[r*8+n] * cmat[k*8+n];
                end
                y[r*8+k] = wrap(s >>> 6, 11);      // Floor then 11 bits
            end
        end
        for (int j = 0; j < 8; j++) begin
            for (int k = 0; k < 8; k++) begin
                s = 0;
                for (int r = 0; r < 8; r++) begin
                    s = s + y[r*8+j] * cmat[k*8+r];
                end
                z[k*8+j] = wrap(s >>> 6, 14);      // k is vertical frequency
            end
        end
        for (int p = 0; p < 64; p++) begin
            exp_q.push_back(z[zz[p]]);
        end
        for (int p = 0; p < n_pairs; p++) begin
            tid_q.push_back(blk_tid);
        end
        blk_in++;
    endtask

    task automatic capture_row();
        if (in_row == 0) begin
            blk_tid = test_id;
        end
        for (int n = 0; n < 8; n++) begin
            x_blk[in_row*8+n] = int'(di[n]);
        end
        if (in_row == 7) begin
            in_row = 0;
            push_block();
        end else begin
            in_row++;
        end
    endtask

    task automatic check_value(int tid, string what, int expv, int actv);
        if (expv != actv) begin
            $display("[ERROR] %s: block %0d pair %0d %s expected %0d actual %0d",
                     test_name(tid), blk_out, beat_idx, what, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic check_pair();
        int e0;
        int e1;
        int tid;
        if (exp_q.size() < 2) begin
            $display("Output beat with q_cnt %0d arrived with no block pending", q_cnt);
            err_cnt++;
        end else begin
            e0  = exp_q.pop_front();
            e1  = exp_q.pop_front();
            tid = tid_q.pop_front();
            check_value(tid, "q_cnt", beat_idx, int'(q_cnt));
            check_value(tid, "q[0]", e0, int'(q[0]));
            check_value(tid, "q[1]", e1, int'(q[1]));
            if (beat_idx == n_pairs - 1) begin
                beat_idx = 0;
                blk_out++;
            end else begin
                beat_idx++;
            end
        end
    endtask

    task automatic check_idle(string phase);
        if (q_valid !== 1'b0) begin
            $display("[ERROR] %s: q_valid expected 0 actual %b", phase, q_valid);
            err_cnt++;
        end
        if (di_hold !== 1'b0) begin
            $display("[ERROR] %s: di_hold expected 0 actual %b", phase, di_hold);
            err_cnt++;
        end
    endtask

    // --------------------------------------------------
    // Monitor, values seen before the edge updates them
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!arst_n) begin
            check_idle("reset");
            rst_seen = 1'b1;
        end else begin
            if (rst_seen) begin
                check_idle("after_reset");    // First cycle out of reset
                rst_seen = 1'b0;
            end
            if (di_valid && !di_hold) begin
                capture_row();
            end
            if (q_valid && !q_hold) begin
                check_pair();
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/dct_2d_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dct_2d_tb;

    localparam int n_blocks       = 40;
    localparam int timeout_cycles = n_blocks * 64 * 4 + 2000;

    logic                clk;
    logic                arst_n;
    dct_pkg::sample_t    di [8];
    logic                di_valid;
    logic                di_hold;
    dct_pkg::coef2_t     q [2];
    logic                q_valid;
    logic                q_hold;
    scan_pkg::pair_cnt_t q_cnt;
    int                  test_id;       // Tag for the checker
    int                  err_cnt;
    int                  blk_in;
    int                  blk_out;
    logic [31:0]         rng;
    logic                hold_en;       // Random q_hold on
    logic                gap_en;        // Random di_valid gaps on
    dct_pkg::sample_t    blk [64];      // Next block, row major

    tb_clock_gen #(.period_ns(10), .rst_cycles(16)) u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dct_2d uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .di       (di),
        .di_valid (di_valid),
        .di_hold  (di_hold),
        .q        (q),
        .q_valid  (q_valid),
        .q_hold   (q_hold),
        .q_cnt    (q_cnt)
    );

    dct_2d_checker u_chk (
        .clk(clk), .arst_n(arst_n),
        .di(di), .di_valid(di_valid), .di_hold(di_hold),
        .q(q), .q_valid(q_valid), .q_hold(q_hold), .q_cnt(q_cnt),
        .test_id(test_id), .err_cnt(err_cnt), .blk_in(blk_in), .blk_out(blk_out)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // One clock, q_hold redrawn for the next edge
    task automatic step();
        q_hold <= hold_en && ((next_rand() % 100) < 40);
        @(posedge clk);
    endtask

    // --------------------------------------------------
    // Block driver, valid/hold rule on di
    // --------------------------------------------------
    task automatic drive_block(int tid);
        for (int r = 0; r < 8; r++) begin
            while (gap_en && ((next_rand() % 100) < 30)) begin
                di_valid <= 1'b0;
                step();
            end
            for (int n = 0; n < 8; n++) begin
                di[n] <= blk[r*8+n];
            end
            di_valid <= 1'b1;
            test_id  <= tid;
            step();
            while (di_hold) begin
                step();                 // Row stays put while held
            end
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d, blocks in %0d, blocks out %0d", err_cnt, blk_in, blk_out);
    endtask

    initial begin
        rng      = 32'd49;
        hold_en  = 1'b0;
        gap_en   = 1'b0;
        di_valid = 1'b0;
        q_hold   = 1'b0;
        test_id  = 0;
        for (int n = 0; n < 8; n++) begin
            di[n] = '0;
        end
        while (arst_n !== 1'b1) @(posedge clk);

        for (int b = 0; b < 4; b++) begin                  // Constant blocks, DC only
            for (int i = 0; i < 64; i++) begin
                blk[i] = (b == 0) ? 8'sd0 : (b == 1) ? 8'sd127 :
                         (b == 2) ? -8'sd128 : dct_pkg::sample_t'(rng);
            end
            drive_block(0);
        end
        for (int b = 0; b < 8; b++) begin                  // Full rate, no hold
            for (int i = 0; i < 64; i++) begin
                blk[i] = dct_pkg::sample_t'(next_rand());
            end
            drive_block(1);
        end
        hold_en = 1'b1;
        gap_en  = 1'b1;
        for (int b = 0; b < 16; b++) begin                 // Gaps and back-pressure
            for (int i = 0; i < 64; i++) begin
                blk[i] = dct_pkg::sample_t'(next_rand());
            end
            drive_block(2);
        end
        gap_en = 1'b0;
        for (int b = 0; b < 4; b++) begin                  // Single impulse
            for (int i = 0; i < 64; i++) begin
                blk[i] = '0;
            end
            blk[next_rand() % 64] = dct_pkg::sample_t'(next_rand() | 32'd1);
            drive_block(3);
        end
        hold_en = 1'b0;
        for (int b = 0; b < 8; b++) begin                  // -128 / 127 patterns
            for (int r = 0; r < 8; r++) begin
                for (int c = 0; c < 8; c++) begin
                    case (b % 4)
                        0:       blk[r*8+c] = ((r + c) % 2 == 1) ? 8'sd127 : -8'sd128;
                        1:       blk[r*8+c] = (c % 2 == 1) ? 8'sd127 : -8'sd128;
                        2:       blk[r*8+c] = (r % 2 == 1) ? 8'sd127 : -8'sd128;
                        default: blk[r*8+c] = ((r / 2 + c / 2) % 2 == 1) ? 8'sd127 : -8'sd128;
                    endcase
                    if (b >= 4) begin
                        blk[r*8+c] = (blk[r*8+c] == 8'sd127) ? -8'sd128 : 8'sd127;
                    end
                end
            end
            drive_block(4);
        end
        di_valid <= 1'b0;

        while (blk_out < n_blocks) begin
            step();
        end
        repeat (100) step();                               // Window for stray beats
        print_counts();
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d of %0d blocks out",
                 timeout_cycles, blk_out, n_blocks);
        print_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns  = 10,      // Clock period
    parameter int rst_cycles = 16       // Cycles with arst_n low
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Released on a rising edge, flops stay in reset through that edge
    initial begin
        arst_n <= 1'b0;                 // Edge seen once every flop is waiting on it
        repeat (rst_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/dct_1d.sv ====
`timescale 1ns/100ps
`default_nettype none

module dct_1d #(
    parameter int in_w  = dct_pkg::sample_w,    // Input sample width
    parameter int out_w = dct_pkg::coef1_w      // Output coefficient width
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic signed [in_w-1:0]  di [8],     // One row or column
    input  logic                    di_valid,
    output logic                    di_hold,
    output logic signed [out_w-1:0] q [8],      // Eight coefficients, k = 0..7
    output logic                    q_valid,
    input  logic                    q_hold
);

    localparam int prod_w = in_w + dct_pkg::cos_w;  // Full product
    localparam int sum_w  = prod_w + 3;             // Eight products, no overflow

    logic                     s1_valid;     // Stage 1 holds products
    logic                     s2_load;      // Stage 1 moves into stage 2
    logic                     di_acc;       // Input beat taken
    logic signed [prod_w-1:0] prod [64];    // Index k*8 + n
    logic signed [sum_w-1:0]  acc  [8];
    logic signed [sum_w-1:0]  shr  [8];

    // --------------------------------------------------
    // Pipeline control
    // --------------------------------------------------
    // Stage 2 takes new data when empty or when its beat leaves this cycle
    assign s2_load = s1_valid && (!q_valid || !q_hold);
    // Stage 1 is free when empty or draining into stage 2
    assign di_hold = s1_valid && !s2_load;
    assign di_acc  = di_valid && !di_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            q_valid  <= 1'b0;
        end else begin
            if (di_acc) begin
                s1_valid <= 1'b1;               // Refilled
            end else if (s2_load) begin
                s1_valid <= 1'b0;               // Drained, nothing behind
            end
            if (s2_load) begin
                q_valid <= 1'b1;
            end else if (!q_hold) begin
                q_valid <= 1'b0;                // Output taken
            end
        end
    end

    // --------------------------------------------------
    // Stage 1, all 64 products
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (di_acc) begin
            for (int k = 0; k < 8; k++) begin
                for (int n = 0; n < 8; n++) begin
                    prod[k*8+n] <= di[n] * dct_pkg::cos_table[k*8+n];
                end
            end
        end
    end

    // --------------------------------------------------
    // Stage 2, row sums and scaling
    // --------------------------------------------------
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            acc[k] = '0;
            for (int n = 0; n < 8; n++) begin
                acc[k] = acc[k] + sum_w'(prod[k*8+n]);  // Sign extended
            end
            shr[k] = acc[k] >>> dct_pkg::cos_shift;     // Floor, not rounded
        end
    end

    always_ff @(posedge clk) begin
        if (s2_load) begin
            for (int k = 0; k < 8; k++) begin
                q[k] <= shr[k][out_w-1:0];  // Keep low out_w bits
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dct_2d.sv ====
`timescale 1ns/100ps
`default_nettype none

module dct_2d #(
    parameter int sample_w = dct_pkg::sample_w,     // Input samples
    parameter int coef1_w  = dct_pkg::coef1_w,      // Between the passes
    parameter int coef2_w  = dct_pkg::coef2_w       // Final coefficients
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  dct_pkg::sample_t     di [8],        // One block row per beat
    input  logic                 di_valid,
    output logic                 di_hold,
    output dct_pkg::coef2_t      q [2],         // Coefficient pair, zigzag order
    output logic                 q_valid,
    input  logic                 q_hold,
    output scan_pkg::pair_cnt_t  q_cnt          // 31 closes a block
);

    logic signed [coef1_w-1:0] row_q [8];       // Row pass result
    logic                      row_valid;
    logic                      row_hold;
    logic signed [coef1_w-1:0] col_d [8];       // Transposed, one column per beat
    logic                      col_valid;
    logic                      col_hold;
    logic signed [coef2_w-1:0] col_q [8];       // Column pass result
    logic                      col_valid2;
    logic                      col_hold2;

    // --------------------------------------------------
    // Row pass
    // --------------------------------------------------
    dct_1d #(
        .in_w   (sample_w),
        .out_w  (coef1_w)
    ) u_row (
        .clk        (clk),
        .arst_n     (arst_n),
        .di         (di),
        .di_valid   (di_valid),
        .di_hold    (di_hold),
        .q          (row_q),
        .q_valid    (row_valid),
        .q_hold     (row_hold)
    );

    // Rows in, columns out
    transpose #(.data_w(coef1_w)) u_tp (
        .clk        (clk),
        .arst_n     (arst_n),
        .d          (row_q),
        .d_valid    (row_valid),
        .d_hold     (row_hold),
        .q          (col_d),
        .q_valid    (col_valid),
        .q_hold     (col_hold)
    );

    // --------------------------------------------------
    // Column pass and scan reorder
    // --------------------------------------------------
    dct_1d #(
        .in_w   (coef1_w),
        .out_w  (coef2_w)
    ) u_col (
        .clk        (clk),
        .arst_n     (arst_n),
        .di         (col_d),
        .di_valid   (col_valid),
        .di_hold    (col_hold),
        .q          (col_q),
        .q_valid    (col_valid2),
        .q_hold     (col_hold2)
    );

    zigzag #(.data_w(coef2_w)) u_zz (
        .clk        (clk),
        .arst_n     (arst_n),
        .d          (col_q),
        .d_valid    (col_valid2),
        .d_hold     (col_hold2),
        .q          (q),
        .q_valid    (q_valid),
        .q_hold     (q_hold),
        .q_cnt      (q_cnt)
    );

endmodule

`default_nettype wire

// ==== rtl/dct_pkg.sv ====
`default_nettype none

package dct_pkg;

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------
    localparam int sample_w  = 8;     // Level-shifted sample, -128..127
    localparam int coef1_w   = 11;    // After the row pass
    localparam int coef2_w   = 14;    // After the column pass
    localparam int cos_w     = 8;     // Signed cosine table entry
    localparam int cos_shift = 6;     // Removes the x64 table scale

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [coef1_w-1:0]  coef1_t;
    typedef logic signed [coef2_w-1:0]  coef2_t;

    // --------------------------------------------------
    // Cosine basis, row k is frequency k, column n is sample n
    // --------------------------------------------------
    // round(64 * c(k) * cos((2n+1)k*pi/16)), c(0) = sqrt(1/8), else 1/2
    localparam logic signed [cos_w-1:0] cos_table [64] = '{
        8'sd23,  8'sd23,  8'sd23,  8'sd23,  8'sd23,  8'sd23,  8'sd23,  8'sd23,
        8'sd31,  8'sd27,  8'sd18,  8'sd6,  -8'sd6,  -8'sd18, -8'sd27, -8'sd31,
        8'sd30,  8'sd12, -8'sd12, -8'sd30, -8'sd30, -8'sd12,  8'sd12,  8'sd30,
        8'sd27, -8'sd6,  -8'sd31, -8'sd18,  8'sd18,  8'sd31,  8'sd6,  -8'sd27,
        8'sd23, -8'sd23, -8'sd23,  8'sd23,  8'sd23, -8'sd23, -8'sd23,  8'sd23,
        8'sd18, -8'sd31,  8'sd6,   8'sd27, -8'sd27, -8'sd6,   8'sd31, -8'sd18,
        8'sd12, -8'sd30,  8'sd30, -8'sd12, -8'sd12,  8'sd30, -8'sd30,  8'sd12,
        8'sd6,  -8'sd18,  8'sd27, -8'sd31,  8'sd31, -8'sd27,  8'sd18, -8'sd6
    };

endpackage

`default_nettype wire

// ==== rtl/scan_pkg.sv ====
`default_nettype none

package scan_pkg;

    // --------------------------------------------------
    // Block geometry and counters
    // --------------------------------------------------
    localparam int blk_n = 8;              // Side of a block

    typedef logic [2:0] row_cnt_t;         // Row or column index
    typedef logic [4:0] pair_cnt_t;        // Output pair index, 32 per block

    // --------------------------------------------------
    // Zigzag scan, position -> natural index (row*8 + col)
    // --------------------------------------------------
    // Row is the vertical frequency, col the horizontal one
    localparam logic [5:0] zz_order [64] = '{
        6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
        6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
        6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
        6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
        6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
        6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
        6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
        6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
    };

endpackage

`default_nettype wire

// ==== rtl/transpose.sv ====
`timescale 1ns/100ps
`default_nettype none

module transpose #(
    parameter int data_w = dct_pkg::coef1_w
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic signed [data_w-1:0] d [8],     // One row per beat
    input  logic                     d_valid,
    output logic                     d_hold,
    output logic signed [data_w-1:0] q [8],     // One column per beat
    output logic                     q_valid,
    input  logic                     q_hold
);

    localparam scan_pkg::row_cnt_t last_idx = scan_pkg::row_cnt_t'(scan_pkg::blk_n - 1);

    // Two banks, [bank][row][col]
    logic signed [data_w-1:0] mem [2][scan_pkg::blk_n][scan_pkg::blk_n];

    scan_pkg::row_cnt_t wr_row;     // Next row to write
    scan_pkg::row_cnt_t rd_col;     // Next column to read
    logic               wr_bank;
    logic               rd_bank;
    logic [1:0]         full;       // Bank holds a complete block
    logic               wr_acc;
    logic               rd_acc;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    assign d_hold  = &full;             // No free bank left
    assign wr_acc  = d_valid && !d_hold;
    assign q_valid = full[rd_bank];     // Oldest block ready
    assign rd_acc  = q_valid && !q_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_row  <= '0;
            rd_col  <= '0;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            full    <= '0;
        end else begin
            if (wr_acc) begin
                wr_row <= wr_row + 1'b1;    // Wraps after row 7
                if (wr_row == last_idx) begin
                    full[wr_bank] <= 1'b1;
                    wr_bank       <= ~wr_bank;
                end
            end
            if (rd_acc) begin
                rd_col <= rd_col + 1'b1;
                if (rd_col == last_idx) begin
                    full[rd_bank] <= 1'b0;  // Last column out, bank free
                    rd_bank       <= ~rd_bank;
                end
            end
        end
    end

    // --------------------------------------------------
    // Storage, rows in and columns out
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            for (int c = 0; c < scan_pkg::blk_n; c++) begin
                mem[wr_bank][wr_row][c] <= d[c];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < scan_pkg::blk_n; r++) begin
            q[r] = mem[rd_bank][r][rd_col];  // Stable while held
        end
    end

endmodule

`default_nettype wire

// ==== rtl/zigzag.sv ====
`timescale 1ns/100ps
`default_nettype none

module zigzag #(
    parameter int data_w = dct_pkg::coef2_w
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic signed [data_w-1:0] d [8],     // Column j, element i = coef (i, j)
    input  logic                     d_valid,
    output logic                     d_hold,
    output logic signed [data_w-1:0] q [2],     // Zigzag positions 2p and 2p+1
    output logic                     q_valid,
    input  logic                     q_hold,
    output scan_pkg::pair_cnt_t      q_cnt      // Pair index p
);

    localparam scan_pkg::row_cnt_t  last_col  = scan_pkg::row_cnt_t'(scan_pkg::blk_n - 1);
    localparam scan_pkg::pair_cnt_t last_pair =
        scan_pkg::pair_cnt_t'(scan_pkg::blk_n * scan_pkg::blk_n / 2 - 1);

    // [bank][row][col], natural order
    logic signed [data_w-1:0] mem [2][scan_pkg::blk_n][scan_pkg::blk_n];

    scan_pkg::row_cnt_t wr_col;     // Next column to store
    logic               wr_bank;
    logic               rd_bank;
    logic [1:0]         full;
    logic               wr_acc;
    logic               rd_acc;
    logic [5:0]         nat0;       // Natural index of even position
    logic [5:0]         nat1;       // Odd position

    // --------------------------------------------------
    // Handshake and counters
    // --------------------------------------------------
    assign d_hold  = &full;
    assign wr_acc  = d_valid && !d_hold;
    assign q_valid = full[rd_bank];
    assign rd_acc  = q_valid && !q_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_col  <= '0;
            q_cnt   <= '0;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            full    <= '0;
        end else begin
            if (wr_acc) begin
                wr_col <= wr_col + 1'b1;
                if (wr_col == last_col) begin
                    full[wr_bank] <= 1'b1;  // Block complete
                    wr_bank       <= ~wr_bank;
                end
            end
            if (rd_acc) begin
                q_cnt <= q_cnt + 1'b1;      // 31 wraps to 0
                if (q_cnt == last_pair) begin
                    full[rd_bank] <= 1'b0;
                    rd_bank       <= ~rd_bank;
                end
            end
        end
    end

    // --------------------------------------------------
    // Storage and scan lookup
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            for (int i = 0; i < scan_pkg::blk_n; i++) begin
                mem[wr_bank][i][wr_col] <= d[i];    // Natural index i*8 + j
            end
        end
    end

    assign nat0 = scan_pkg::zz_order[{q_cnt, 1'b0}];
    assign nat1 = scan_pkg::zz_order[{q_cnt, 1'b1}];
    assign q[0] = mem[rd_bank][nat0[5:3]][nat0[2:0]];  // Upper bits pick the row
    assign q[1] = mem[rd_bank][nat1[5:3]][nat1[2:0]];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the dct_2d testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module dct_2d_tb \
    -f sources.f \
    -o sim_dct_2d > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_dct_2d > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

// ==== sources.f ====
rtl/dct_pkg.sv
rtl/scan_pkg.sv
rtl/dct_1d.sv
rtl/transpose.sv
rtl/zigzag.sv
rtl/dct_2d.sv
dv/tb_clock_gen.sv
dv/dct_2d_checker.sv
dv/dct_2d_tb.sv
